// ==== tb.f ====
rtl/coreDefs.sv
rtl/ctrlIf.sv
rtl/ctrlDecoder.sv
rtl/regFile.sv
rtl/alu.sv
rtl/mdu.sv
rtl/execCore.sv
verif/tbChecker.sv
verif/tbTop.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log &&
verilator --binary --timing --assert -f tb.f --top-module tbTop -o simv &&
./obj_dir/simv > sim.log 2>&1 || echo "run.sh: build or simulation step failed"
cat sim.log 2>/dev/null
grep -qx "Simulation passed" sim.log || { echo "run.sh: no pass line in sim.log"; exit 1; }

// ==== verif/tbTop.sv ====
module tbTop import coreDefs::*; ();

	localparam int NUM_CYCLES  = 3000;
	localparam int STALL_LIMIT = DIV_CYCLES + 2;

	logic        clk;
	logic        arstN;
	logic [31:0] instr;
	logic        instrValid;
	logic        stall;
	logic        wbEn;
	logic [4:0]  wbAddr;
	logic [31:0] wbData;
	logic        excRI;
	logic        excOv;
	int          valueErrors;
	int          otherErrors;
	integer      seed;

	execCore execCore_inst (.*);

	tbChecker scoreboard (.*);

	always #20 clk = ~clk;

	////////////////////
	// Instruction generation
	function automatic logic [31:0] keptInstr();
		logic [4:0]  rs, rt, rd, sh;
		logic [15:0] imm;
		int          pick;
		rs = 5'({$random(seed)} % 8);  // Few registers for more reuse
		rt = 5'({$random(seed)} % 8);
		rd = 5'({$random(seed)} % 8);
		sh = 5'($random(seed));
		imm = 16'($random(seed));
		pick = {$random(seed)} % 22;
		case (pick)
			1:  return {OP_R, rs, rt, rd, 5'd0, FN_ADD};
			2:  return {OP_R, rs, rt, rd, 5'd0, FN_ADDU};
			3:  return {OP_R, rs, rt, rd, 5'd0, FN_SUB};
			4:  return {OP_R, rs, rt, rd, 5'd0, FN_AND};
			5:  return {OP_R, rs, rt, rd, 5'd0, FN_OR};
			6:  return {OP_R, rs, rt, rd, 5'd0, FN_SLT};
			7:  return {OP_R, rs, rt, rd, 5'd0, FN_SLTU};
			8:  return {OP_R, 5'd0, rt, rd, sh, FN_SRL};
			9:  return {OP_ADDI, rs, rt, imm};
			10: return {OP_ADDIU, rs, rt, imm};
			11: return {OP_ANDI, rs, rt, imm};
			12: return {OP_ORI, rs, rt, imm};
			13: return {OP_LUI, 5'd0, rt, imm};
			14: return {OP_R, rs, rt, 10'd0, FN_MULT};
			15: return {OP_R, rs, rt, 10'd0, FN_MULTU};
			16: return {OP_R, rs, rt, 10'd0, FN_DIV};   // rt of r0 divides by zero
			17: return {OP_R, rs, rt, 10'd0, FN_DIVU};
			18: return {OP_R, 10'd0, rd, 5'd0, FN_MFHI};
			19: return {OP_R, 10'd0, rd, 5'd0, FN_MFLO};
			20: return {OP_R, rs, 15'd0, FN_MTHI};
			21: return {OP_R, rs, 15'd0, FN_MTLO};
			default: return 32'd0;  // nop
		endcase
	endfunction

	// lw opcode or R-type syscall funct
	function automatic logic [31:0] reservedInstr();
		logic [31:0] raw;
		raw = $random(seed);
		return raw[0] ? {6'h23, raw[25:0]} : {OP_R, raw[25:6], 6'h0c};
	endfunction

	initial begin
		int   stallRun;
		int   sel;
		logic stuck;
		seed = 32'hcd4c;
		clk = 1'b0;
		arstN = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		stallRun = 0;
		stuck = 1'b0;
		repeat (4) @(posedge clk);
		#2 arstN = 1'b1;
		for (int n = 0; n < NUM_CYCLES && !stuck; n++) begin
			@(negedge clk);
			if (instrValid && stall)
				stallRun++;  // Held instruction not taken at next edge
			else
				stallRun = 0;
			@(posedge clk);
			#2;
			if (stallRun > STALL_LIMIT) begin
				$display("Stall stayed high for more than %0d cycles", STALL_LIMIT);
				stuck = 1'b1;
			end else if (stallRun == 0) begin
				sel = {$random(seed)} % 20;
				instrValid = (sel >= 2);
				if (sel < 2)
					instr = $random(seed);  // Idle with junk on the bus
				else if (sel < 4)
					instr = reservedInstr();
				else
					instr = keptInstr();
			end
		end
		// Let the last accepted instruction report
		@(posedge clk);
		#2 instrValid = 1'b0;
		repeat (2) @(negedge clk);
		$display("Error counts: %0d value, %0d other", valueErrors,
			otherErrors + int'(stuck));
		if (valueErrors == 0 && otherErrors == 0 && !stuck)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== verif/tbChecker.sv ====
module tbChecker import coreDefs::*; (
	input  logic        clk,
	input  logic        arstN,
	input  logic [31:0] instr,
	input  logic        instrValid,
	input  logic        stall,
	input  logic        wbEn,
	input  logic [4:0]  wbAddr,
	input  logic [31:0] wbData,
	input  logic        excRI,
	input  logic        excOv,
	output int          valueErrors,
	output int          otherErrors
);

	localparam int RESET_TIMEOUT = 20;

	logic [31:0] regs [32];
	logic [31:0] hi, lo;
	logic [31:0] pendHi, pendLo;  // Mult/div result waiting for busy to fall
	logic [31:0] expData;
	logic [4:0]  expAddr;
	logic        expWb, expRI, expOv;
	logic        expStall;
	int          busyLeft;
	int          waitCycles;

	task automatic mismatch(input string what, input logic [31:0] want, input logic [31:0] got);
		$display("ERROR @%0t: %s expected %h got %h", $time, what, want, got);
		valueErrors++;
	endtask

	// Value does not fit a signed 32-bit word
	function automatic logic overflows(input longint v);
		longint back;
		back = longint'($signed(v[31:0]));
		return back != v;
	endfunction

	////////////////////
	// Port comparison
	task automatic compareOutputs();
		expStall = instrValid && (busyLeft != 0) && (instr[31:26] == OP_R) &&
			(instr[5:0] inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU,
			FN_MFHI, FN_MFLO, FN_MTHI, FN_MTLO});
		if (stall !== expStall)
			mismatch("stall", 32'(expStall), 32'(stall));
		if (wbEn !== expWb)
			mismatch("wbEn", 32'(expWb), 32'(wbEn));
		else if (expWb && wbAddr !== expAddr)
			mismatch("wbAddr", 32'(expAddr), 32'(wbAddr));
		else if (expWb && wbData !== expData)
			mismatch($sformatf("wbData for r%0d", expAddr), expData, wbData);
		if (excRI !== expRI)
			mismatch("excRI", 32'(expRI), 32'(excRI));
		if (excOv !== expOv)
			mismatch("excOv", 32'(expOv), 32'(excOv));
	endtask

	////////////////////
	// Reference model of one accepted instruction
	task automatic applyInstr();
		logic [31:0] a, b, res;
		logic [4:0]  dest;
		logic        write, trap, bad;
		longint      sa, sb, s, q, r;
		a = regs[instr[25:21]];
		b = regs[instr[20:16]];
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		dest = instr[15:11];
		res = '0;
		write = 1'b1;
		trap = 1'b0;
		bad = 1'b0;
		if (instr == 32'd0)
			write = 1'b0;  // nop
		else if (instr[31:26] == OP_R) begin
			case (instr[5:0])
				FN_ADD: begin
					s = sa + sb;
					res = s[31:0];
					trap = overflows(s);
				end
				FN_SUB: begin
					s = sa - sb;
					res = s[31:0];
					trap = overflows(s);
				end
				FN_ADDU: res = a + b;
				FN_AND:  res = a & b;
				FN_OR:   res = a | b;
				FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
				FN_SRL:  res = b >> instr[10:6];
				FN_MFHI: res = hi;
				FN_MFLO: res = lo;
				FN_MTHI, FN_MTLO: begin
					write = 1'b0;
					if (instr[5:0] == FN_MTHI)
						hi = a;
					else
						lo = a;
				end
				FN_MULT, FN_MULTU: begin
					write = 1'b0;
					if (instr[5:0] == FN_MULT)
						{pendHi, pendLo} = sa * sb;
					else
						{pendHi, pendLo} = {32'd0, a} * {32'd0, b};
					busyLeft = MULT_CYCLES;
				end
				FN_DIV, FN_DIVU: begin
					write = 1'b0;
					if (b == 32'd0)
						{pendHi, pendLo} = {a, 32'hffff_ffff};  // Divide by zero
					else if (instr[5:0] == FN_DIV) begin
						q = sa / sb;
						r = sa % sb;
						{pendHi, pendLo} = {r[31:0], q[31:0]};
					end else
						{pendHi, pendLo} = {a % b, a / b};
					busyLeft = DIV_CYCLES;
				end
				default: bad = 1'b1;
			endcase
		end else begin
			dest = instr[20:16];  // I-type writes rt
			case (instr[31:26])
				OP_ADDI: begin
					s = sa + longint'($signed(instr[15:0]));
					res = s[31:0];
					trap = overflows(s);
				end
				OP_ADDIU: res = a + {{16{instr[15]}}, instr[15:0]};
				OP_ANDI:  res = a & {16'd0, instr[15:0]};
				OP_ORI:   res = a | {16'd0, instr[15:0]};
				OP_LUI:   res = {instr[15:0], 16'd0};
				default:  bad = 1'b1;
			endcase
		end
		expRI = bad;
		expOv = trap;
		expWb = write && !bad && !trap && (dest != 5'd0);
		expAddr = dest;
		expData = res;
		if (expWb)
			regs[dest] = res;
	endtask

	// One rising edge of the model
	task automatic advanceModel();
		expWb = 1'b0;
		expRI = 1'b0;
		expOv = 1'b0;
		if (busyLeft != 0) begin
			busyLeft--;
			if (busyLeft == 0)
				{hi, lo} = {pendHi, pendLo};  // HI/LO load as busy falls
		end
		if (instrValid && !expStall)
			applyInstr();
	endtask

	initial begin
		valueErrors = 0;
		otherErrors = 0;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		hi = '0;
		lo = '0;
		busyLeft = 0;
		expWb = 1'b0;
		expRI = 1'b0;
		expOv = 1'b0;
		expStall = 1'b0;
		waitCycles = 0;
		while (arstN !== 1'b1 && waitCycles < RESET_TIMEOUT) begin
			@(negedge clk);
			waitCycles++;
		end
		if (arstN !== 1'b1) begin
			$display("Reset was not released within %0d cycles", RESET_TIMEOUT);
			otherErrors++;
		end else begin
			// Negedge sampling once all ports settle
			forever begin
				compareOutputs();
				advanceModel();
				@(negedge clk);
			end
		end
	end

endmodule

// ==== rtl/execCore.sv ====
module execCore import coreDefs::*; (
	input  logic        clk,
	input  logic        arstN,
	input  logic [31:0] instr,
	input  logic        instrValid,
	output logic        stall,
	output logic        wbEn,
	output logic [4:0]  wbAddr,
	output logic [31:0] wbData,
	output logic        excRI,
	output logic        excOv
);

	logic [31:0] rsData;
	logic [31:0] rtData;
	logic [31:0] immExt;
	logic [31:0] opB;
	logic [31:0] aluRes;
	logic [31:0] hiLoOut;
	logic [31:0] wrData;
	logic [4:0]  wrAddr;
	logic        aluOvf;
	logic        mduBusy;
	logic        accept;
	logic        wrEn;

	ctrlIf ctrlBus ();

	ctrlDecoder ctrlDecoder_inst (.instr(instr), .ctrl(ctrlBus));

	////////////////////
	// Operand and destination selection
	assign immExt = ctrlBus.immSigned ? {{16{instr[15]}}, instr[15:0]} : {16'd0, instr[15:0]};
	assign opB    = ctrlBus.srcImm ? immExt : rtData;
	assign wrAddr = ctrlBus.regDst ? instr[15:11] : instr[20:16];
	assign wrData = ctrlBus.selMdu ? hiLoOut : aluRes;

	// Hold any MDU access while a mult/div runs
	assign stall  = instrValid && mduBusy && (ctrlBus.mduOp != MDU_NONE);
	assign accept = instrValid && !stall;
	assign wrEn   = accept && ctrlBus.regWrite && !aluOvf && !ctrlBus.resIns;

	regFile regFile_inst (
		.clk(clk), .arstN(arstN),
		.rsAddr(instr[25:21]), .rtAddr(instr[20:16]),
		.wrAddr(wrAddr), .wrEn(wrEn), .wrData(wrData),
		.rsData(rsData), .rtData(rtData),
		.wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
	);

	alu alu_inst (.a(rsData), .b(opB), .shamt(instr[10:6]), .ctrl(ctrlBus),
		.result(aluRes), .ovf(aluOvf));

	mdu mdu_inst (.clk(clk), .arstN(arstN), .go(accept), .a(rsData), .b(rtData),
		.ctrl(ctrlBus), .busy(mduBusy), .hiLoOut(hiLoOut));

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			excRI <= 1'b0;
			excOv <= 1'b0;
		end else begin
			excRI <= accept && ctrlBus.resIns;
			excOv <= accept && aluOvf;  // Write already suppressed
		end
	end

endmodule

// ==== rtl/mdu.sv ====
module mdu import coreDefs::*; (
	input  logic        clk,
	input  logic        arstN,
	input  logic        go,       // Accept strobe
	input  logic [31:0] a,
	input  logic [31:0] b,
	ctrlIf.exec         ctrl,
	output logic        busy,
	output logic [31:0] hiLoOut
);

	logic [31:0]        hi;
	logic [31:0]        lo;
	logic [31:0]        pendHi;
	logic [31:0]        pendLo;
	logic [3:0]         cnt;
	logic signed [63:0] prodS;
	logic [63:0]        prodU;
	logic [63:0]        result;  // {HI, LO}

	wire isStart = (ctrl.mduOp == MDU_MULT) || (ctrl.mduOp == MDU_MULTU) ||
		(ctrl.mduOp == MDU_DIV) || (ctrl.mduOp == MDU_DIVU);

	assign prodS = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
	assign prodU = {32'd0, a} * {32'd0, b};

	////////////////////
	// Result of the pending operation
	always_comb begin
		unique case (ctrl.mduOp)
			MDU_MULT:  result = prodS;
			MDU_DIV:   result = (b == 32'd0) ? {a, 32'hffff_ffff}
				: {32'($signed(a) % $signed(b)), 32'($signed(a) / $signed(b))};
			MDU_DIVU:  result = (b == 32'd0) ? {a, 32'hffff_ffff} : {a % b, a / b};
			default:   result = prodU;
		endcase
	end

	always_ff @(posedge clk) begin
		if (go && isStart)
			{pendHi, pendLo} <= result;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			cnt <= 4'd0;
			hi  <= '0;
			lo  <= '0;
		end else begin
			if (cnt != 4'd0)
				cnt <= cnt - 4'd1;
			if (cnt == 4'd1) begin  // Busy falls here
				hi <= pendHi;
				lo <= pendLo;
			end
			if (go) begin
				unique case (ctrl.mduOp)
					MDU_MULT, MDU_MULTU: cnt <= 4'(MULT_CYCLES);
					MDU_DIV, MDU_DIVU:   cnt <= 4'(DIV_CYCLES);
					MDU_MTHI:            hi  <= a;
					MDU_MTLO:            lo  <= a;
					default: ;
				endcase
			end
		end
	end

	assign busy    = (cnt != 4'd0);
	assign hiLoOut = (ctrl.mduOp == MDU_MFHI) ? hi : lo;

	// Stall in execCore must hold back new starts
	noStartBusy: assert property (@(posedge clk) disable iff (!arstN) go && isStart |-> !busy)
		else $error("MDU start accepted while busy");

endmodule

// ==== rtl/alu.sv ====
module alu import coreDefs::*; (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [4:0]  shamt,
	ctrlIf.exec         ctrl,
	output logic [31:0] result,
	output logic        ovf
);

	logic [31:0] sum;
	logic [31:0] diff;
	logic        addOv;
	logic        subOv;

	assign sum  = a + b;
	assign diff = a - b;

	// Signed overflow from operand and result signs
	assign addOv = (a[31] == b[31]) && (sum[31] != a[31]);
	assign subOv = (a[31] != b[31]) && (diff[31] != a[31]);

	always_comb begin
		unique case (ctrl.aluOp)
			ALU_ADD:  result = sum;
			ALU_SUB:  result = diff;
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_LUI:  result = {b[15:0], 16'd0};
			ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
			ALU_SLTU: result = {31'd0, a < b};
			ALU_SRL:  result = b >> shamt;
			default:  result = sum;
		endcase
	end

	assign ovf = ctrl.trapOv && ((ctrl.aluOp == ALU_ADD && addOv) ||
		(ctrl.aluOp == ALU_SUB && subOv));

endmodule

// ==== rtl/regFile.sv ====
module regFile (
	input  logic        clk,
	input  logic        arstN,
	input  logic [4:0]  rsAddr,
	input  logic [4:0]  rtAddr,
	input  logic [4:0]  wrAddr,
	input  logic        wrEn,
	input  logic [31:0] wrData,
	output logic [31:0] rsData,
	output logic [31:0] rtData,
	output logic        wbEn,
	output logic [4:0]  wbAddr,
	output logic [31:0] wbData
);

	logic [31:0] regs [32];

	wire doWrite = wrEn && (wrAddr != 5'd0);  // r0 stays zero

	assign rsData = regs[rsAddr];
	assign rtData = regs[rtAddr];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
			wbEn <= 1'b0;
		end else begin
			if (doWrite)
				regs[wrAddr] <= wrData;
			wbEn <= doWrite;  // Report one cycle later
		end
	end

	always_ff @(posedge clk) begin
		wbAddr <= wrAddr;
		wbData <= wrData;
	end

	wbNoR0: assert property (@(posedge clk) disable iff (!arstN) wbEn |-> wbAddr != 5'd0)
		else $error("write report for r0");

endmodule

// ==== rtl/ctrlDecoder.sv ====
module ctrlDecoder import coreDefs::*; (
	input logic [31:0] instr,
	ctrlIf.decode      ctrl
);

	wire [5:0] op    = instr[31:26];
	wire [5:0] funct = instr[5:0];
	wire       isR   = (op == OP_R);

	////////////////////
	// One flag per kept instruction
	wire iNop   = (instr == 32'd0);
	wire iAdd   = isR && (funct == FN_ADD);
	wire iAddu  = isR && (funct == FN_ADDU);
	wire iSub   = isR && (funct == FN_SUB);
	wire iAnd   = isR && (funct == FN_AND);
	wire iOr    = isR && (funct == FN_OR);
	wire iSlt   = isR && (funct == FN_SLT);
	wire iSltu  = isR && (funct == FN_SLTU);
	wire iSrl   = isR && (funct == FN_SRL);
	wire iMult  = isR && (funct == FN_MULT);
	wire iMultu = isR && (funct == FN_MULTU);
	wire iDiv   = isR && (funct == FN_DIV);
	wire iDivu  = isR && (funct == FN_DIVU);
	wire iMfhi  = isR && (funct == FN_MFHI);
	wire iMflo  = isR && (funct == FN_MFLO);
	wire iMthi  = isR && (funct == FN_MTHI);
	wire iMtlo  = isR && (funct == FN_MTLO);
	wire iAddi  = (op == OP_ADDI);
	wire iAddiu = (op == OP_ADDIU);
	wire iAndi  = (op == OP_ANDI);
	wire iOri   = (op == OP_ORI);
	wire iLui   = (op == OP_LUI);

	wire rAlu = iAdd | iAddu | iSub | iAnd | iOr | iSlt | iSltu | iSrl;
	wire immOp = iAddi | iAddiu | iAndi | iOri | iLui;
	wire mduAny = iMult | iMultu | iDiv | iDivu | iMfhi | iMflo | iMthi | iMtlo;

	////////////////////
	// Control fields
	assign ctrl.srcImm    = immOp;
	assign ctrl.immSigned = iAddi | iAddiu;  // andi, ori, lui zero extend
	assign ctrl.regDst    = rAlu | iMfhi | iMflo;
	assign ctrl.regWrite  = rAlu | immOp | iMfhi | iMflo;
	assign ctrl.selMdu    = iMfhi | iMflo;
	assign ctrl.trapOv    = iAdd | iSub | iAddi;
	assign ctrl.resIns    = !(iNop | rAlu | immOp | mduAny);

	always_comb begin
		ctrl.aluOp = ALU_ADD;  // add, addu, addi, addiu
		if (iSub)
			ctrl.aluOp = ALU_SUB;
		else if (iAnd | iAndi)
			ctrl.aluOp = ALU_AND;
		else if (iOr | iOri)
			ctrl.aluOp = ALU_OR;
		else if (iLui)
			ctrl.aluOp = ALU_LUI;
		else if (iSlt)
			ctrl.aluOp = ALU_SLT;
		else if (iSltu)
			ctrl.aluOp = ALU_SLTU;
		else if (iSrl)
			ctrl.aluOp = ALU_SRL;
	end

	always_comb begin
		ctrl.mduOp = MDU_NONE;
		if (iMult)
			ctrl.mduOp = MDU_MULT;
		else if (iMultu)
			ctrl.mduOp = MDU_MULTU;
		else if (iDiv)
			ctrl.mduOp = MDU_DIV;
		else if (iDivu)
			ctrl.mduOp = MDU_DIVU;
		else if (iMfhi)
			ctrl.mduOp = MDU_MFHI;
		else if (iMflo)
			ctrl.mduOp = MDU_MFLO;
		else if (iMthi)
			ctrl.mduOp = MDU_MTHI;
		else if (iMtlo)
			ctrl.mduOp = MDU_MTLO;
	end

	// Only mfhi/mflo both write a register and touch the MDU
	always_comb begin
		assert (!(ctrl.regWrite && ctrl.mduOp != MDU_NONE) || ctrl.selMdu)
			else $error("decoder sets regWrite together with an MDU start");
	end

endmodule

// ==== rtl/ctrlIf.sv ====
interface ctrlIf import coreDefs::*; ();

	aluOpE aluOp;
	logic  srcImm;     // B operand from immediate
	logic  immSigned;  // Sign extend imm
	logic  regDst;     // 1 selects rd, 0 selects rt
	logic  regWrite;
	logic  selMdu;     // Write data from HI/LO
	mduOpE mduOp;
	logic  trapOv;     // Trap on signed overflow
	logic  resIns;     // Reserved instruction

	modport decode (output aluOp, srcImm, immSigned, regDst, regWrite,
		selMdu, mduOp, trapOv, resIns);

	modport exec (input aluOp, srcImm, immSigned, regDst, regWrite,
		selMdu, mduOp, trapOv, resIns);

endinterface

// ==== rtl/coreDefs.sv ====
package coreDefs;

	////////////////////
	// Opcode field encodings
	localparam logic [5:0] OP_R     = 6'b000000;
	localparam logic [5:0] OP_ADDI  = 6'b001000;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_ANDI  = 6'b001100;
	localparam logic [5:0] OP_ORI   = 6'b001101;
	localparam logic [5:0] OP_LUI   = 6'b001111;

	////////////////////
	// Funct field encodings of R-type
	localparam logic [5:0] FN_SRL   = 6'b000010;
	localparam logic [5:0] FN_MFHI  = 6'b010000;
	localparam logic [5:0] FN_MTHI  = 6'b010001;
	localparam logic [5:0] FN_MFLO  = 6'b010010;
	localparam logic [5:0] FN_MTLO  = 6'b010011;
	localparam logic [5:0] FN_MULT  = 6'b011000;
	localparam logic [5:0] FN_MULTU = 6'b011001;
	localparam logic [5:0] FN_DIV   = 6'b011010;
	localparam logic [5:0] FN_DIVU  = 6'b011011;
	localparam logic [5:0] FN_ADD   = 6'b100000;
	localparam logic [5:0] FN_ADDU  = 6'b100001;
	localparam logic [5:0] FN_SUB   = 6'b100010;
	localparam logic [5:0] FN_AND   = 6'b100100;
	localparam logic [5:0] FN_OR    = 6'b100101;
	localparam logic [5:0] FN_SLT   = 6'b101010;
	localparam logic [5:0] FN_SLTU  = 6'b101011;

	////////////////////
	// Execution unit operations
	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
		ALU_LUI, ALU_SLT, ALU_SLTU, ALU_SRL
	} aluOpE;

	typedef enum logic [3:0] {
		MDU_NONE, MDU_MULT, MDU_MULTU, MDU_DIV, MDU_DIVU,
		MDU_MFHI, MDU_MFLO, MDU_MTHI, MDU_MTLO
	} mduOpE;

	// Busy cycles after a start
	localparam int MULT_CYCLES = 5;
	localparam int DIV_CYCLES  = 10;

endpackage
